// ==== Makefile ====
# Verilator flow for the UART testbench
TOP = tb_uart_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f build.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '^\*\* PASS \*\*$$' sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
testbench/uart_asserts.sv
testbench/tb_uart_top.sv

// ==== rtl/uart_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared UART definitions for the transmitter, the receiver
// and the testbench. Bit timing is fixed at build time here
// and the frame is 8N1 with the LSB sent first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_pkg;

   // clock cycles spent on every serial bit
   localparam int cycles_per_bit = 16;

   // distance from the start edge to the middle of the start bit
   localparam int half_bit = cycles_per_bit / 2;

   // payload bits in one frame
   localparam int data_bits = 8;

   // start bit, data bits and one stop bit
   localparam int frame_bits = data_bits + 2;

   // bit index counters have to reach frame_bits - 1
   localparam int bit_cnt_w = 4;

   // the bit period counter runs from 0 to cycles_per_bit - 1
   localparam int tick_cnt_w = $clog2(cycles_per_bit);

   // one byte on either stream
   typedef logic [data_bits-1:0] uart_byte_t;

endpackage

// ==== rtl/uart_rx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver. Synchronises rxd, finds the start edge and
// samples every bit at its centre. A good frame lands in a
// one-byte holding register read over valid/ready. overflow and
// framing_error are single-cycle pulses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_rx (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 rxd,
   output logic                 valid,
   input  logic                 ready,
   output uart_pkg::uart_byte_t data,
   output logic                 overflow,
   output logic                 framing_error
);
   import uart_pkg::*;

   typedef enum logic [2:0] {
      st_wait_high,
      st_idle,
      st_start,
      st_data,
      st_stop
   } rx_state_t;

   logic                  rxd_meta_q;
   logic                  rxd_sync_q;
   rx_state_t             state_q;
   logic [tick_cnt_w-1:0] tick_q;
   logic [bit_cnt_w-1:0]  bit_idx_q;
   uart_byte_t            shift_q;
   uart_byte_t            hold_q;
   logic                  valid_q;
   logic                  overflow_q;
   logic                  framing_q;
   logic                  start_centre;
   logic                  bit_end;
   logic                  last_data;
   logic                  byte_done;
   logic                  stop_bad;
   logic                  load;

   // two flops before anything looks at the line
   always_ff @(posedge clk) begin
      if (rst) begin
         rxd_meta_q <= 1'b1;
         rxd_sync_q <= 1'b1;
      end else begin
         rxd_meta_q <= rxd;
         rxd_sync_q <= rxd_meta_q;
      end
   end

   assign start_centre = (state_q == st_start) && (tick_q == tick_cnt_w'(half_bit - 1));
   assign bit_end      = (tick_q == tick_cnt_w'(cycles_per_bit - 1));
   assign last_data    = (bit_idx_q == bit_cnt_w'(data_bits - 1));
   assign byte_done    = (state_q == st_stop) && bit_end && rxd_sync_q;
   assign stop_bad     = (state_q == st_stop) && bit_end && !rxd_sync_q;

   // a new byte is kept only when the holding register is free or emptied now
   assign load = byte_done && (!valid_q || ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= st_wait_high;
         tick_q    <= '0;
         bit_idx_q <= '0;
      end else begin
         case (state_q)
            st_wait_high: begin
               tick_q <= '0;
               if (rxd_sync_q) begin
                  state_q <= st_idle;
               end
            end
            st_idle: begin
               tick_q <= '0;
               if (!rxd_sync_q) begin
                  state_q <= st_start; // the line was high before, so this is a falling edge
               end
            end
            st_start: begin
               if (start_centre) begin
                  tick_q    <= '0;
                  bit_idx_q <= '0;
                  // a start bit that is high again at its centre was only a glitch
                  state_q   <= rxd_sync_q ? st_idle : st_data;
               end else begin
                  tick_q <= tick_q + 1'b1;
               end
            end
            st_data: begin
               if (bit_end) begin
                  tick_q    <= '0;
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (last_data) begin
                     state_q <= st_stop;
                  end
               end else begin
                  tick_q <= tick_q + 1'b1;
               end
            end
            st_stop: begin
               if (bit_end) begin
                  tick_q  <= '0;
                  state_q <= st_wait_high; // good or bad, wait for an idle line
               end else begin
                  tick_q <= tick_q + 1'b1;
               end
            end
            default: begin
               state_q <= st_wait_high;
            end
         endcase
      end
   end

   // data arrives LSB first, so shift in from the top
   always_ff @(posedge clk) begin
      if ((state_q == st_data) && bit_end) begin
         shift_q <= {rxd_sync_q, shift_q[data_bits-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         hold_q <= shift_q;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q    <= 1'b0;
         overflow_q <= 1'b0;
         framing_q  <= 1'b0;
      end else begin
         if (load) begin
            valid_q <= 1'b1;
         end else if (ready) begin
            valid_q <= 1'b0;
         end
         overflow_q <= byte_done && valid_q && !ready; // the new byte is dropped and the old one stays
         framing_q  <= stop_bad;
      end
   end

   assign valid         = valid_q;
   assign data          = hold_q;
   assign overflow      = overflow_q;
   assign framing_error = framing_q;

endmodule

// ==== rtl/uart_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART top level. Transmitter and receiver side by side, each
// with its own byte stream. The serial loop is closed outside
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_top (
   input  logic                 clk,
   input  logic                 rst,

   // transmit byte stream
   input  logic                 tx_valid,
   output logic                 tx_ready,
   input  uart_pkg::uart_byte_t tx_data,

   // serial line out, idles high
   output logic                 txd,

   // serial line in
   input  logic                 rxd,

   // receive byte stream
   output logic                 rx_valid,
   input  logic                 rx_ready,
   output uart_pkg::uart_byte_t rx_data,

   // one-cycle status pulses from the receiver
   output logic                 overflow,
   output logic                 framing_error
);

   // the transmit side has no extra register between the port and the core
   uart_tx tx_i (
      .clk   (clk),
      .rst   (rst),
      .valid (tx_valid),
      .ready (tx_ready),
      .data  (tx_data),
      .txd   (txd)
   );

   // receive side
   uart_rx rx_i (
      .clk           (clk),
      .rst           (rst),
      .rxd           (rxd),
      .valid         (rx_valid),
      .ready         (rx_ready),
      .data          (rx_data),
      .overflow      (overflow),
      .framing_error (framing_error)
   );

endmodule

// ==== rtl/uart_tx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmitter. Takes a byte from a valid/ready stream and
// sends it as one start bit, eight data bits LSB first and one
// stop bit. ready stays low until the stop bit has been sent
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_tx (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 valid,
   output logic                 ready,
   input  uart_pkg::uart_byte_t data,
   output logic                 txd
);
   import uart_pkg::*;

   typedef enum logic {
      st_idle,
      st_send
   } tx_state_t;

   tx_state_t             state_q;
   logic [tick_cnt_w-1:0] tick_q;
   logic [bit_cnt_w-1:0]  bit_idx_q;
   logic [frame_bits-1:0] frame_q;
   logic [frame_bits-1:0] frame_d;
   logic                  txd_q;
   logic                  accept;
   logic                  bit_end;
   logic                  last_bit;
   logic                  shift;

   assign ready    = (state_q == st_idle);
   assign accept   = valid && ready;
   assign bit_end  = (tick_q == tick_cnt_w'(cycles_per_bit - 1));
   assign last_bit = (bit_idx_q == bit_cnt_w'(frame_bits - 1));
   assign shift    = (state_q == st_send) && bit_end;
   assign txd      = txd_q; // straight from a flop, so the line never glitches

   // bit 0 of the frame register is always the bit on the line
   always_comb begin
      frame_d = frame_q;
      if (accept) begin
         frame_d = {1'b1, data, 1'b0};
      end else if (shift) begin
         frame_d = {1'b1, frame_q[frame_bits-1:1]}; // ones fill in behind the stop bit
      end
   end

   always_ff @(posedge clk) begin
      frame_q <= frame_d;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= st_idle;
         tick_q    <= '0;
         bit_idx_q <= '0;
      end else begin
         case (state_q)
            st_idle: begin
               tick_q    <= '0;
               bit_idx_q <= '0;
               if (accept) begin
                  state_q <= st_send;
               end
            end
            st_send: begin
               if (bit_end) begin
                  tick_q <= '0;
                  if (last_bit) begin
                     state_q <= st_idle; // the stop bit is done 160 cycles after accept
                  end else begin
                     bit_idx_q <= bit_idx_q + 1'b1;
                  end
               end else begin
                  tick_q <= tick_q + 1'b1;
               end
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   // the start bit goes out in the cycle after the accept edge
   always_ff @(posedge clk) begin
      if (rst) begin
         txd_q <= 1'b1;
      end else if (accept || shift) begin
         txd_q <= frame_d[0]; // after the last shift this is a fill one, so the line idles high
      end
   end

endmodule

// ==== testbench/tb_uart_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for uart_top. rxd comes either from txd (loopback)
// or from a frame generator here, and every received byte and
// status pulse is checked against a reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_uart_top;
   timeunit 1ns;
   timeprecision 100ps;
   import uart_pkg::*;

   localparam int frame_cycles  = frame_bits * cycles_per_bit;
   localparam int loop_bytes    = 50;
   localparam int test_frames   = 1 + loop_bytes + 2 + 2 + 2;
   localparam int margin_cycles = 3000;
   localparam int cycle_limit   = test_frames * frame_cycles + margin_cycles;
   localparam logic [15:0] lfsr_seed = 16'd34472;

   logic       clk;
   logic       rst;
   logic       tx_valid;
   logic       tx_ready;
   uart_byte_t tx_data;
   logic       txd;
   logic       rxd;
   logic       rx_valid;
   logic       rx_ready;
   uart_byte_t rx_data;
   logic       overflow;
   logic       framing_error;

   logic        use_gen;  // 1 selects the frame generator, 0 loops txd back
   logic        gen_line;
   logic [15:0] lfsr_q;
   int          cycle_cnt;

   // reference model
   uart_byte_t exp_q[$];
   uart_byte_t got_q[$];
   logic       held_m;    // model's view of the receiver holding register
   int         exp_ovf;
   int         exp_fe;
   int         ovf_cnt;
   int         fe_cnt;

   uart_top uart_top_i (
      .clk           (clk),
      .rst           (rst),
      .tx_valid      (tx_valid),
      .tx_ready      (tx_ready),
      .tx_data       (tx_data),
      .txd           (txd),
      .rxd           (rxd),
      .rx_valid      (rx_valid),
      .rx_ready      (rx_ready),
      .rx_data       (rx_data),
      .overflow      (overflow),
      .framing_error (framing_error)
   );

   assign rxd = use_gen ? gen_line : txd;

   always #2 clk = ~clk;

   // records every transfer on the receive stream and counts the pulses
   always @(posedge clk) begin
      if (!rst) begin
         if (rx_valid && rx_ready) begin
            got_q.push_back(rx_data);
            held_m = 1'b0; // taken, so the holding register is free again
         end
         if (overflow) begin
            ovf_cnt++;
         end
         if (framing_error) begin
            fe_cnt++;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("ERROR: the run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $fatal(1, "timeout");
      end
   end

   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [7:0] random_bits(input int n);
      logic [7:0] v;
      int k;
      v = '0;
      for (k = 0; k < n; k++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[6:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // what the receiver should do with a frame, given the holding register
   function automatic void predict_frame(input uart_byte_t b, input logic stop_ok);
      if (!stop_ok) begin
         exp_fe++;
      end else if (held_m) begin
         exp_ovf++; // the old byte stays and this one is lost
      end else begin
         exp_q.push_back(b);
         held_m = 1'b1;
      end
   endfunction

   task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
      if (got !== exp) begin
         $display("FAIL at %0.1f ns: %s is 0x%02h, expected 0x%02h", $realtime, name, got, exp);
         $display("** FAIL **");
         $fatal(1, "byte mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL at %0.1f ns: %s is %b, expected %b", $realtime, name, got, exp);
         $display("** FAIL **");
         $fatal(1, "flag mismatch");
      end
   endtask

   // all driving and sampling happens 1 ns after a rising edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_accept();
      logic ready_seen;
      ready_seen = 1'b0;
      while (!ready_seen) begin
         ready_seen = tx_ready;
         step();
      end
   endtask

   task automatic send_byte(input uart_byte_t b);
      tx_data  = b;
      tx_valid = 1'b1;
      wait_accept();
      tx_valid = 1'b0;
      predict_frame(b, 1'b1);
   endtask

   task automatic wait_rx_valid();
      while (!rx_valid) begin
         step();
      end
   endtask

   // starts one cycle after the accept edge and samples every bit centre
   task automatic check_tx_frame(input uart_byte_t b);
      logic exp;
      int k;
      repeat (half_bit) step();
      for (k = 0; k < frame_bits; k++) begin
         if (k == 0) begin
            exp = 1'b0;
         end else if (k == frame_bits - 1) begin
            exp = 1'b1;
         end else begin
            exp = b[k-1]; // LSB first
         end
         check_bit($sformatf("txd bit %0d", k), txd, exp);
         if (k < frame_bits - 1) begin
            repeat (cycles_per_bit) step();
         end
      end
      repeat (half_bit - 1) step();
      check_bit("tx_ready", tx_ready, 1'b0);
      step();
      check_bit("tx_ready", tx_ready, 1'b1);
   endtask

   task automatic gen_frame(input uart_byte_t b, input logic stop_bit);
      int k;
      predict_frame(b, stop_bit);
      for (k = 0; k < frame_bits; k++) begin
         if (k == 0) begin
            gen_line = 1'b0;
         end else if (k == frame_bits - 1) begin
            gen_line = stop_bit;
         end else begin
            gen_line = b[k-1];
         end
         repeat (cycles_per_bit) step();
      end
      gen_line = 1'b1;
   endtask

   task automatic drain_check();
      uart_byte_t got;
      uart_byte_t exp;
      while (got_q.size() > 0) begin
         check_bit("received byte expected by model", exp_q.size() != 0, 1'b1);
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         check_byte("rx_data", got, exp);
      end
      check_bit("all expected bytes received", exp_q.size() == 0, 1'b1);
      check_bit("overflow count matches model", ovf_cnt == exp_ovf, 1'b1);
      check_bit("framing_error count matches model", fe_cnt == exp_fe, 1'b1);
   endtask

   task automatic idle_after_reset();
      check_bit("tx_ready", tx_ready, 1'b1);
      check_bit("txd", txd, 1'b1);
      check_bit("rx_valid", rx_valid, 1'b0);
      check_bit("overflow", overflow, 1'b0);
      check_bit("framing_error", framing_error, 1'b0);
   endtask

   task automatic frame_shape();
      uart_byte_t b;
      rx_ready = 1'b1;
      b = random_bits(data_bits);
      send_byte(b);
      check_tx_frame(b);
      rx_ready = 1'b0;
      drain_check();
   endtask

   task automatic loopback_stream();
      uart_byte_t b;
      logic [7:0] delay;
      int i;
      for (i = 0; i < loop_bytes; i++) begin
         b = random_bits(data_bits);
         send_byte(b);
         wait_rx_valid();
         delay = random_bits(tick_cnt_w); // taken within one bit period
         repeat (delay) step();
         rx_ready = 1'b1;
         step();
         rx_ready = 1'b0;
      end
      drain_check();
   endtask

   task automatic overflow_case();
      uart_byte_t b1;
      uart_byte_t b2;
      rx_ready = 1'b0;
      b1 = random_bits(data_bits);
      b2 = random_bits(data_bits);
      send_byte(b1);
      send_byte(b2);
      while (!tx_ready) begin
         step();
      end
      repeat (cycles_per_bit) step();
      check_bit("overflow count is one", (ovf_cnt == 1) && (exp_ovf == 1), 1'b1);
      check_bit("rx_valid", rx_valid, 1'b1);
      check_byte("rx_data", rx_data, exp_q[0]);
      rx_ready = 1'b1;
      step();
      rx_ready = 1'b0;
      repeat (frame_cycles) step(); // the dropped byte must not show up later
      check_bit("rx_valid", rx_valid, 1'b0);
      drain_check();
   endtask

   task automatic framing_case();
      uart_byte_t b;
      rx_ready = 1'b0;
      use_gen  = 1'b1;
      repeat (cycles_per_bit) step();
      b = random_bits(data_bits);
      gen_frame(b, 1'b0);
      repeat (cycles_per_bit) step();
      check_bit("framing_error count is one", (fe_cnt == 1) && (exp_fe == 1), 1'b1);
      check_bit("rx_valid", rx_valid, 1'b0);
      b = random_bits(data_bits);
      gen_frame(b, 1'b1);
      wait_rx_valid();
      rx_ready = 1'b1;
      step();
      rx_ready = 1'b0;
      use_gen  = 1'b0;
      drain_check();
   endtask

   task automatic tx_backpressure();
      uart_byte_t b1;
      uart_byte_t b2;
      int waits;
      rx_ready = 1'b1;
      b1 = random_bits(data_bits);
      b2 = random_bits(data_bits);
      send_byte(b1);
      tx_data  = b2; // offered while the first frame is still going out
      tx_valid = 1'b1;
      waits    = 0;
      while (!tx_ready) begin
         step();
         waits++;
      end
      check_bit("tx_ready back after one frame", waits == frame_cycles, 1'b1);
      wait_accept();
      tx_valid = 1'b0;
      predict_frame(b2, 1'b1);
      check_tx_frame(b2);
      repeat (cycles_per_bit) step();
      rx_ready = 1'b0;
      drain_check();
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      tx_valid  = 1'b0;
      tx_data   = '0;
      rx_ready  = 1'b0;
      use_gen   = 1'b1; // rxd idles high until txd comes out of reset
      gen_line  = 1'b1;
      lfsr_q    = lfsr_seed;
      cycle_cnt = 0;
      held_m    = 1'b0;
      exp_ovf   = 0;
      exp_fe    = 0;
      ovf_cnt   = 0;
      fe_cnt    = 0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      idle_after_reset();
      use_gen = 1'b0;
      frame_shape();
      loopback_stream();
      overflow_case();
      framing_case();
      tx_backpressure();
      if ((exp_q.size() == 0) && (got_q.size() == 0)) begin
         $display("** PASS **");
         $finish;
      end else begin
         $display("ERROR: received bytes and model queue differ at the end of the run");
         $display("** FAIL **");
         $fatal(1, "leftover bytes");
      end
   end

endmodule

// ==== testbench/uart_asserts.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks for the UART top level, bound into uart_top
// so that they watch both byte streams and the serial output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_asserts (
   input logic                 clk,
   input logic                 rst,
   input logic                 tx_valid,
   input logic                 tx_ready,
   input logic                 txd,
   input logic                 rx_valid,
   input logic                 rx_ready,
   input uart_pkg::uart_byte_t rx_data,
   input logic                 overflow,
   input logic                 framing_error
);
   timeunit 1ns;
   timeprecision 100ps;
   import uart_pkg::*;

   localparam int frame_cycles = frame_bits * cycles_per_bit;

   int since_accept; // 1 right after an accept edge, frame_cycles + 1 when ready is due back

   always_ff @(posedge clk) begin
      if (rst) begin
         since_accept <= 0;
      end else if (tx_valid && tx_ready) begin
         since_accept <= 1;
      end else if ((since_accept != 0) && (since_accept <= frame_cycles)) begin
         since_accept <= since_accept + 1;
      end else begin
         since_accept <= 0;
      end
   end

   // a held byte may not change or vanish before it is taken
   rx_hold_stable: assert property (@(posedge clk) disable iff (rst)
      (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)))
      else $error("rx_data or rx_valid changed while the byte was not taken");

   tx_idle_high: assert property (@(posedge clk) disable iff (rst)
      tx_ready |-> txd)
      else $error("txd low while the transmitter is idle");

   rx_pulses_apart: assert property (@(posedge clk) disable iff (rst)
      !(overflow && framing_error))
      else $error("overflow and framing_error in the same cycle");

   tx_busy_frame: assert property (@(posedge clk) disable iff (rst)
      ((since_accept >= 1) && (since_accept <= frame_cycles)) |-> !tx_ready)
      else $error("tx_ready rose before the frame was sent");

   tx_ready_back: assert property (@(posedge clk) disable iff (rst)
      (since_accept == frame_cycles + 1) |-> tx_ready)
      else $error("tx_ready not back one frame after the accept");

endmodule

bind uart_top uart_asserts asserts_i (
   .clk           (clk),
   .rst           (rst),
   .tx_valid      (tx_valid),
   .tx_ready      (tx_ready),
   .txd           (txd),
   .rx_valid      (rx_valid),
   .rx_ready      (rx_ready),
   .rx_data       (rx_data),
   .overflow      (overflow),
   .framing_error (framing_error)
);
